// File: nabp_mapper_top.f
+incdir+include
logic/nabp_ctrl_pkg.sv
logic/nabp_data_pkg.sv
logic/nabp_cmd_decode.sv
logic/nabp_row_walker.sv
logic/nabp_mapper.sv
logic/nabp_line_buffer.sv
logic/nabp_mapper_top.sv
dv/nabp_clock_gen.sv
dv/nabp_mapper_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= nabp_mapper_tb
FILELIST  ?= nabp_mapper_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/nabp_mapper_tb.sv
`timescale 1ns/1ns
`include "nabp_consts.svh"

module nabp_mapper_tb;

    localparam int ADDR_W  = $clog2(`NABP_LINE_SIZE);
    localparam int CMD_W   = `NABP_ACCU_INT + `NABP_ACCU_FRAC;
    localparam int TIMEOUT = 400;

    logic                        clk;
    logic                        reset_n;
    logic                        cmd_valid;
    nabp_ctrl_pkg::nabp_opcode_e cmd_op;
    logic [CMD_W-1:0]            cmd_data;
    logic                        cmd_ready;
    logic                        load_en;
    logic [ADDR_W-1:0]           load_addr;
    nabp_data_pkg::nabp_sample_t load_data;
    logic                        sample_valid;
    nabp_data_pkg::nabp_sample_t sample_data;
    logic                        sample_in_range;
    logic                        credit_return;

    // reference copy of the line and the samples seen in the current row
    nabp_data_pkg::nabp_sample_t line_model [`NABP_LINE_SIZE];
    nabp_data_pkg::nabp_sample_t got_data [$];
    logic                        got_in_range [$];

    logic [15:0] line_lfsr;
    logic [15:0] gap_lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          received_cnt;
    int          returned_cnt;
    int          credit_level;
    int          gap;
    bit          aborted;
    bit          hold;
    bit          random_gaps;
    bit          ret_prev;

    nabp_clock_gen u_clock_gen (.clk(clk), .reset_n(reset_n));

    nabp_mapper_top u_nabp_mapper_top (
        .clk(clk), .reset_n(reset_n),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_data(cmd_data), .cmd_ready(cmd_ready),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .sample_valid(sample_valid), .sample_data(sample_data),
        .sample_in_range(sample_in_range), .credit_return(credit_return)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(inout logic [15:0] s, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            s   = lfsr_step(s);
            val = {val[30:0], s[0]};
        end
    endtask

    // floor of the fixed-point position at step k
    function automatic int expected_index(input int init, input int base, input int k);
        return (init + k * base) >>> `NABP_ACCU_FRAC;
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
        aborted = 1'b1;
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        tests_run++;
        if (aborted || errors != errors_at_start)
        begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
        else
            $display("test %0d %s: ok", tests_run, name);
    endtask

    task automatic send_cmd(input nabp_ctrl_pkg::nabp_opcode_e op, input int data);
        int waited;
        waited = 0;
        if (aborted)
            return;
        while (!cmd_ready && waited < TIMEOUT)
        begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!cmd_ready)
        begin
            report_timeout("cmd_ready before a command");
            return;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_data  = CMD_W'(data);
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
        cmd_op    = nabp_ctrl_pkg::OP_NOP;
    endtask

    task automatic load_line();
        int val;
        for (int i = 0; i < `NABP_LINE_SIZE; i++)
        begin
            take_bits(line_lfsr, `NABP_DATA_WIDTH, val);
            load_addr = ADDR_W'(i);
            line_model[load_addr] = val[`NABP_DATA_WIDTH-1:0];
            load_data = line_model[load_addr];
            load_en   = 1'b1;
            @(posedge clk);
            #2;
        end
        load_en = 1'b0;
    endtask

    task automatic run_row(input int init, input int base, input int len, input bit withhold);
        int                          waited;
        int                          stalled;
        int                          ret_start;
        int                          idx;
        bit                          exp_in;
        nabp_data_pkg::nabp_sample_t exp_data;
        if (aborted)
            return;
        got_data.delete();
        got_in_range.delete();
        hold      = withhold;
        ret_start = returned_cnt;
        send_cmd(nabp_ctrl_pkg::OP_SET_INIT, init);
        send_cmd(nabp_ctrl_pkg::OP_SET_BASE, base);
        send_cmd(nabp_ctrl_pkg::OP_MAP_ROW, len);
        waited  = 0;
        stalled = 0;
        while (!aborted && got_data.size() < len && waited < TIMEOUT)
        begin
            @(negedge clk);
            #1;
            waited++;
            assert (got_data.size() <= returned_cnt - ret_start + `NABP_CREDITS)
            else
            begin
                $display("Fail at %0t: %0d samples with only %0d credits returned",
                         $time, got_data.size(), returned_cnt - ret_start);
                errors++;
            end
            // busy exactly until the last sample shows up
            assert (cmd_ready == (got_data.size() == len))
            else
            begin
                $display("Fail at %0t: cmd_ready %0b after %0d of %0d samples",
                         $time, cmd_ready, got_data.size(), len);
                errors++;
            end
            // consumer holds back for a while once the credits are used up
            if (hold && got_data.size() >= `NABP_CREDITS)
                stalled++;
            if (stalled > 6)
                hold = 1'b0;
        end
        if (aborted)
            return;
        if (got_data.size() < len)
        begin
            report_timeout("the last sample of the row");
            return;
        end
        waited = 0;
        while (returned_cnt != received_cnt && waited < TIMEOUT)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (returned_cnt != received_cnt)
        begin
            report_timeout("all credits to come back");
            return;
        end
        assert (got_data.size() == len)
        else
        begin
            $display("Fail at %0t: %0d samples for a row of %0d", $time, got_data.size(), len);
            errors++;
        end
        for (int k = 0; k < got_data.size(); k++)
        begin
            idx      = expected_index(init, base, k);
            exp_in   = (idx >= 0) && (idx < `NABP_LINE_SIZE);
            exp_data = exp_in ? line_model[idx[ADDR_W-1:0]] : '0;
            assert (got_data[k] == exp_data && got_in_range[k] == exp_in)
            else
            begin
                $display("Fail at %0t: step %0d got %0h/%0b, expected %0h/%0b", $time, k,
                         got_data[k], got_in_range[k], exp_data, exp_in);
                errors++;
            end
        end
        @(posedge clk);
        #2;
    endtask

    // sample collector and credit model
    // a step needs a credit in its own cycle
    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            credit_level = `NABP_CREDITS;
            ret_prev     = 1'b0;
        end
        else
        begin
            if (sample_valid)
            begin
                assert (credit_level > 0)
                else
                begin
                    $display("Fail at %0t: sample after a step cycle without a credit", $time);
                    errors++;
                end
                got_data.push_back(sample_data);
                got_in_range.push_back(sample_in_range);
                received_cnt++;
                credit_level--;
            end
            if (ret_prev)
                credit_level++;
            ret_prev = credit_return;
        end
    end

    // credit consumer returning at most one credit per cycle
    always @(posedge clk)
    begin
        #2;
        credit_return = 1'b0;
        if (reset_n && !hold && received_cnt > returned_cnt)
        begin
            if (gap == 0)
            begin
                credit_return = 1'b1;
                returned_cnt++;
                if (random_gaps)
                    take_bits(gap_lfsr, 2, gap);
            end
            else
                gap--;
        end
    end

    initial
    begin
        int waited;
        int start;
        cmd_valid     = 1'b0;
        cmd_op        = nabp_ctrl_pkg::OP_NOP;
        cmd_data      = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        credit_return = 1'b0;
        line_lfsr     = 16'd5012;
        gap_lfsr      = 16'd5012;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        received_cnt  = 0;
        returned_cnt  = 0;
        credit_level  = `NABP_CREDITS;
        gap           = 0;
        aborted       = 1'b0;
        hold          = 1'b0;
        random_gaps   = 1'b0;
        ret_prev      = 1'b0;

        waited = 0;
        while (reset_n !== 1'b1 && waited < 10)
        begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (reset_n !== 1'b1)
            report_timeout("reset release");
        start = errors;
        @(negedge clk);
        assert (cmd_ready && !sample_valid)
        else
        begin
            $display("Fail at %0t: after reset cmd_ready %0b sample_valid %0b",
                     $time, cmd_ready, sample_valid);
            errors++;
        end
        @(posedge clk);
        #2;
        report_test("reset state", start);

        load_line();
        start = errors;
        run_row(128, 192, 20, 1'b0);
        report_test("in-range row", start);

        // starts left of the line and runs past its end
        start = errors;
        run_row(-700, 400, 20, 1'b0);
        report_test("out-of-range steps", start);

        start = errors;
        random_gaps = 1'b1;
        run_row(0, 256, 16, 1'b1);
        report_test("withheld credits", start);

        start = errors;
        random_gaps = 1'b0;
        run_row(64, 64, 3, 1'b0);
        send_cmd(nabp_ctrl_pkg::OP_MAP_ROW, 0);
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            assert (cmd_ready && !sample_valid)
            else
            begin
                $display("Fail at %0t: zero-length row gave cmd_ready %0b sample_valid %0b",
                         $time, cmd_ready, sample_valid);
                errors++;
            end
        end
        @(posedge clk);
        #2;
        report_test("cmd_ready and empty row", start);

        start = errors;
        random_gaps = 1'b1;
        load_line();
        run_row(64, 136, 30, 1'b0);
        report_test("sample timing", start);

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !aborted)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: dv/nabp_clock_gen.sv
`timescale 1ns/1ns

module nabp_clock_gen
(
    output logic clk,
    output logic reset_n
);

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial
    begin
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

// File: logic/nabp_mapper_top.sv
`timescale 1ns/1ns
`include "nabp_consts.svh"

module nabp_mapper_top
(
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     cmd_valid,
    input  nabp_ctrl_pkg::nabp_opcode_e              cmd_op,
    input  logic [`NABP_ACCU_INT+`NABP_ACCU_FRAC-1:0] cmd_data,
    output logic                                     cmd_ready,
    input  logic                                     load_en,
    input  logic [$clog2(`NABP_LINE_SIZE)-1:0]       load_addr,
    input  nabp_data_pkg::nabp_sample_t              load_data,
    output logic                                     sample_valid,
    output nabp_data_pkg::nabp_sample_t              sample_data,
    output logic                                     sample_in_range,
    input  logic                                     credit_return
);

    logic                       kick;
    logic                       shift_en;
    logic                       done;
    logic                       in_range;
    logic [`NABP_ROW_WIDTH-1:0] row_len;
    nabp_data_pkg::nabp_accu_t  accu_init;
    nabp_data_pkg::nabp_accu_t  accu_base;
    nabp_data_pkg::nabp_s_val_t s_val;

    // decode
    nabp_cmd_decode u_cmd_decode (
        .clk(clk), .reset_n(reset_n),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_data(cmd_data), .cmd_ready(cmd_ready),
        .done(done), .kick(kick), .row_len(row_len),
        .accu_init(accu_init), .accu_base(accu_base)
    );

    // execute
    nabp_row_walker u_row_walker (
        .clk(clk), .reset_n(reset_n), .kick(kick), .row_len(row_len),
        .credit_return(credit_return), .shift_en(shift_en), .done(done)
    );

    nabp_mapper u_mapper (
        .clk(clk), .reset_n(reset_n), .accu_init(accu_init), .accu_base(accu_base),
        .kick(kick), .shift_en(shift_en), .done(done), .s_val(s_val), .in_range(in_range)
    );

    // result
    nabp_line_buffer u_line_buffer (
        .clk(clk), .reset_n(reset_n),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .shift_en(shift_en), .s_val(s_val), .in_range(in_range),
        .sample_valid(sample_valid), .sample_data(sample_data),
        .sample_in_range(sample_in_range)
    );

endmodule

// File: logic/nabp_line_buffer.sv
`timescale 1ns/1ns
`include "nabp_consts.svh"

module nabp_line_buffer
(
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 load_en,
    input  logic [$clog2(`NABP_LINE_SIZE)-1:0]   load_addr,
    input  nabp_data_pkg::nabp_sample_t          load_data,
    input  logic                                 shift_en,
    input  nabp_data_pkg::nabp_s_val_t           s_val,
    input  logic                                 in_range,
    output logic                                 sample_valid,
    output nabp_data_pkg::nabp_sample_t          sample_data,
    output logic                                 sample_in_range
);

    localparam int ADDR_W = $clog2(`NABP_LINE_SIZE);

    nabp_data_pkg::nabp_sample_t mem [`NABP_LINE_SIZE];

    // host load port, one sample per cycle
    always_ff @(posedge clk)
    begin
        if (load_en)
            mem[load_addr] <= load_data;
    end

    // registered lookup, zero outside the line
    always_ff @(posedge clk)
    begin
        if (shift_en)
        begin
            sample_in_range <= in_range;
            if (in_range)
                sample_data <= mem[s_val[ADDR_W-1:0]];
            else
                sample_data <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= shift_en;
    end

endmodule

// File: logic/nabp_mapper.sv
`timescale 1ns/1ns
`include "nabp_consts.svh"

module nabp_mapper
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  nabp_data_pkg::nabp_accu_t  accu_init,
    input  nabp_data_pkg::nabp_accu_t  accu_base,
    input  logic                       kick,
    input  logic                       shift_en,
    input  logic                       done,
    output nabp_data_pkg::nabp_s_val_t s_val,
    output logic                       in_range
);

    nabp_ctrl_pkg::nabp_walk_state_e state;
    nabp_data_pkg::nabp_accu_t       accu;

    // valid window is [0, line size) in fixed point
    assign in_range = (state == nabp_ctrl_pkg::MAPPING) && (accu >= 0) &&
                      (accu < (`NABP_LINE_SIZE << `NABP_ACCU_FRAC));

    // floor of the accumulator before this step's increment
    assign s_val = in_range ? accu[`NABP_ACCU_FRAC +: `NABP_S_WIDTH] : '0;

    always_ff @(posedge clk)
    begin
        if (state == nabp_ctrl_pkg::READY)
            accu <= accu_init;
        else if (shift_en)
            accu <= accu + accu_base;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_ctrl_pkg::READY;
        else if (state == nabp_ctrl_pkg::READY && kick)
            state <= nabp_ctrl_pkg::MAPPING;
        else if (state == nabp_ctrl_pkg::MAPPING && done)
            state <= nabp_ctrl_pkg::READY;
    end

endmodule

// File: logic/nabp_row_walker.sv
`timescale 1ns/1ns
`include "nabp_consts.svh"

module nabp_row_walker
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       kick,
    input  logic [`NABP_ROW_WIDTH-1:0] row_len,
    input  logic                       credit_return,
    output logic                       shift_en,
    output logic                       done
);

    localparam int CREDIT_W = $clog2(`NABP_CREDITS + 1);

    nabp_ctrl_pkg::nabp_walk_state_e state;
    logic [CREDIT_W-1:0]             credits;
    logic [`NABP_ROW_WIDTH-1:0]      remaining;

    // one step per cycle while credits last
    assign shift_en = (state == nabp_ctrl_pkg::MAPPING) && (credits != '0);
    assign done     = shift_en && (remaining == `NABP_ROW_WIDTH'd1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state     <= nabp_ctrl_pkg::READY;
            credits   <= CREDIT_W'(`NABP_CREDITS);
            remaining <= '0;
        end
        else
        begin
            // step and return in one cycle cancel out
            if (shift_en && !credit_return)
                credits <= credits - 1'b1;
            else if (credit_return && !shift_en)
                credits <= credits + 1'b1;

            case (state)
                nabp_ctrl_pkg::READY:
                    if (kick)
                    begin
                        state     <= nabp_ctrl_pkg::MAPPING;
                        remaining <= row_len;
                    end
                nabp_ctrl_pkg::MAPPING:
                begin
                    if (shift_en)
                        remaining <= remaining - 1'b1;
                    if (done)
                        state <= nabp_ctrl_pkg::READY;
                end
                default:
                    state <= nabp_ctrl_pkg::READY;
            endcase
        end
    end

endmodule

// File: logic/nabp_cmd_decode.sv
`timescale 1ns/1ns
`include "nabp_consts.svh"

module nabp_cmd_decode
(
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     cmd_valid,
    input  nabp_ctrl_pkg::nabp_opcode_e              cmd_op,
    input  logic [`NABP_ACCU_INT+`NABP_ACCU_FRAC-1:0] cmd_data,
    output logic                                     cmd_ready,
    input  logic                                     done,
    output logic                                     kick,
    output logic [`NABP_ROW_WIDTH-1:0]               row_len,
    output nabp_data_pkg::nabp_accu_t                accu_init,
    output nabp_data_pkg::nabp_accu_t                accu_base
);

    nabp_ctrl_pkg::nabp_decode_state_e state;
    logic                              cmd_fire;
    logic [`NABP_ROW_WIDTH-1:0]        cmd_len;
    logic                              map_start;

    assign cmd_ready = (state == nabp_ctrl_pkg::IDLE);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign cmd_len   = cmd_data[`NABP_ROW_WIDTH-1:0];

    // zero-length rows are dropped here
    assign map_start = cmd_fire && (cmd_op == nabp_ctrl_pkg::OP_MAP_ROW) && (cmd_len != '0);

    // parameter registers
    always_ff @(posedge clk)
    begin
        if (cmd_fire && cmd_op == nabp_ctrl_pkg::OP_SET_INIT)
            accu_init <= nabp_data_pkg::nabp_accu_t'(cmd_data);
        if (cmd_fire && cmd_op == nabp_ctrl_pkg::OP_SET_BASE)
            accu_base <= nabp_data_pkg::nabp_accu_t'(cmd_data);
        if (map_start)
            row_len <= cmd_len;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_ctrl_pkg::IDLE;
            kick  <= 1'b0;
        end
        else
        begin
            // kick follows the accepted command by one cycle
            kick <= map_start;
            case (state)
                nabp_ctrl_pkg::IDLE:
                    if (map_start)
                        state <= nabp_ctrl_pkg::BUSY;
                nabp_ctrl_pkg::BUSY:
                    if (done)
                        state <= nabp_ctrl_pkg::IDLE;
                default:
                    state <= nabp_ctrl_pkg::IDLE;
            endcase
        end
    end

endmodule

// File: logic/nabp_data_pkg.sv
`include "nabp_consts.svh"

package nabp_data_pkg;

    // fixed-point accumulator, floor shift by the fraction width
    typedef logic signed [`NABP_ACCU_INT+`NABP_ACCU_FRAC-1:0] nabp_accu_t;

    // index into the projection line
    typedef logic signed [`NABP_S_WIDTH-1:0] nabp_s_val_t;

    // one projection sample
    typedef logic [`NABP_DATA_WIDTH-1:0] nabp_sample_t;

endpackage

// File: logic/nabp_ctrl_pkg.sv
package nabp_ctrl_pkg;

    // host command opcodes
    typedef enum logic [1:0] {
        OP_NOP      = 2'd0,
        OP_SET_INIT = 2'd1,
        OP_SET_BASE = 2'd2,
        OP_MAP_ROW  = 2'd3
    } nabp_opcode_e;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } nabp_decode_state_e;

    // shared by the walker and the mapper
    typedef enum logic {
        READY   = 1'b0,
        MAPPING = 1'b1
    } nabp_walk_state_e;

endpackage

// File: include/nabp_consts.svh
`ifndef NABP_CONSTS_SVH
`define NABP_CONSTS_SVH

// samples per projection line
`define NABP_LINE_SIZE 16
// signed sample index
`define NABP_S_WIDTH 5

// accumulator fixed-point format, integer and fraction bits
`define NABP_ACCU_INT 6
`define NABP_ACCU_FRAC 8

`define NABP_DATA_WIDTH 12
`define NABP_ROW_WIDTH 6
`define NABP_CREDITS 4

`endif
